// ==== hw/fetch_pkg.sv ====
// Shared fetch types and widths. XLEN and the register index width are fixed for RV32I.
package fetch_pkg;

	localparam int XLEN = 32;
	localparam int REG_INDEX_WIDTH = 5;

	// Major opcodes in the low seven bits of the instruction word
	typedef enum logic [6:0] {
		OPC_OTHER  = 7'b0000000,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_SYSTEM = 7'b1110011,
		// Fused multiply-add family uses the R4 format
		OPC_MADD   = 7'b1000011,
		OPC_MSUB   = 7'b1000111,
		OPC_NMSUB  = 7'b1001011,
		OPC_NMADD  = 7'b1001111
	} opcode_e;

	// What fetch must do after a word
	typedef enum logic [1:0] {
		FLOW_SEQUENTIAL = 2'd0,
		FLOW_WAIT_JUMP  = 2'd1,
		FLOW_WAIT_IRQ   = 2'd2
	} flow_class_e;

	typedef enum logic [1:0] {
		ST_FETCH     = 2'd0,
		ST_WAIT_JUMP = 2'd1,
		ST_WAIT_IRQ  = 2'd2
	} fetch_state_e;

	// Full-word encodings of the system instructions that stop fetch
	localparam logic [XLEN-1:0] INSN_ECALL = 32'h0000_0073;
	localparam logic [XLEN-1:0] INSN_WFI   = 32'h1050_0073;
	localparam logic [XLEN-1:0] INSN_MRET  = 32'h3020_0073;

endpackage

// ==== hw/fetch_predecode.sv ====
// Purely combinational and covers only the RV32I formats plus R4. SYSTEM words use the I format.
module fetch_predecode (
	input  logic [fetch_pkg::XLEN-1:0]            i_instruction,
	output fetch_pkg::opcode_e                    o_opcode,
	output fetch_pkg::flow_class_e                o_flow,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rs1,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rs2,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rs3,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rd
);
	import fetch_pkg::*;

	logic is_r;
	logic is_i;
	logic is_s;
	logic is_b;
	logic is_u;
	logic is_j;
	logic is_r4;

	// Unknown opcodes collapse to OPC_OTHER
	always_comb begin
		case (i_instruction[6:0])
			OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_LUI, OPC_AUIPC,
			OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_SYSTEM,
			OPC_MADD, OPC_MSUB, OPC_NMSUB, OPC_NMADD: begin
				o_opcode = opcode_e'(i_instruction[6:0]);
			end
			default: begin
				o_opcode = OPC_OTHER;
			end
		endcase
	end

	always_comb begin
		is_r = (o_opcode == OPC_OP);
		is_i = (o_opcode inside {OPC_LOAD, OPC_OP_IMM, OPC_JALR, OPC_SYSTEM});
		is_s = (o_opcode == OPC_STORE);
		is_b = (o_opcode == OPC_BRANCH);
		is_u = (o_opcode inside {OPC_LUI, OPC_AUIPC});
		is_j = (o_opcode == OPC_JAL);
		is_r4 = (o_opcode inside {OPC_MADD, OPC_MSUB, OPC_NMSUB, OPC_NMADD});
	end

	// Indices go to the register file early, so absent fields read as x0
	assign o_rs1 = (is_r | is_i | is_s | is_b | is_r4) ? i_instruction[19:15] : '0;
	assign o_rs2 = (is_r | is_s | is_b | is_r4) ? i_instruction[24:20] : '0;
	assign o_rs3 = is_r4 ? i_instruction[31:27] : '0;
	assign o_rd = (is_r | is_i | is_u | is_j | is_r4) ? i_instruction[11:7] : '0;

	always_comb begin
		if (is_j || is_b || o_opcode == OPC_JALR || i_instruction == INSN_MRET) begin
			// Target unknown here, decode supplies it later
			o_flow = FLOW_WAIT_JUMP;
		end
		else if (i_instruction == INSN_ECALL || i_instruction == INSN_WFI) begin
			o_flow = FLOW_WAIT_IRQ;
		end
		else begin
			o_flow = FLOW_SEQUENTIAL;
		end
	end

endmodule

// ==== hw/fetch_apb_requester.sv ====
// Read-only APB requester with one transfer at a time. Done, data and error are valid in the PREADY cycle.
module fetch_apb_requester (
	input  logic                       i_clock,
	input  logic                       i_reset,
	input  logic                       i_start,
	input  logic [fetch_pkg::XLEN-1:0] i_address,
	output logic                       o_done,
	output logic [fetch_pkg::XLEN-1:0] o_rdata,
	output logic                       o_error,
	output logic                       o_psel,
	output logic                       o_penable,
	output logic [fetch_pkg::XLEN-1:0] o_paddr,
	input  logic [fetch_pkg::XLEN-1:0] i_prdata,
	input  logic                       i_pready,
	input  logic                       i_pslverr
);
	import fetch_pkg::*;

	logic            r_access;
	logic [XLEN-1:0] r_address;

	// The start cycle is the setup phase
	assign o_psel = i_start | r_access;
	assign o_penable = r_access;
	assign o_paddr = r_access ? r_address : i_address;

	// Word goes straight to the result buffer register
	assign o_done = r_access & i_pready;
	assign o_rdata = i_prdata;
	assign o_error = r_access & i_pslverr;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			r_access <= 1'b0;
		end
		else if (i_start) begin
			r_access <= 1'b1;
		end
		else if (r_access && i_pready) begin
			r_access <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_start) begin
			r_address <= i_address;
		end
	end

	a_no_start_in_flight: assert property (@(posedge i_clock) disable iff (i_reset)
		i_start |-> !r_access)
		else $error("APB start issued while a transfer is in flight");

	a_addr_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		r_access |-> $stable(o_paddr))
		else $error("APB address changed during the access phase");

endmodule

// ==== hw/fetch_sequencer.sv ====
// Holds one fetch in flight at most. i_jump is honoured only in ST_WAIT_JUMP and irq edges wait there.
module fetch_sequencer #(
	parameter logic [fetch_pkg::XLEN-1:0] RESET_VECTOR = '0
) (
	input  logic                       i_clock,
	input  logic                       i_reset,
	input  logic                       i_jump,
	input  logic [fetch_pkg::XLEN-1:0] i_jump_pc,
	input  logic                       i_irq_pending,
	input  logic [fetch_pkg::XLEN-1:0] i_irq_pc,
	output logic                       o_irq_dispatched,
	output logic [fetch_pkg::XLEN-1:0] o_irq_epc,
	output logic                       o_start,
	output logic [fetch_pkg::XLEN-1:0] o_address,
	input  logic                       i_done,
	input  logic                       i_error,
	input  fetch_pkg::flow_class_e     i_flow,
	input  logic                       i_room,
	output logic                       o_push,
	output logic [fetch_pkg::XLEN-1:0] o_push_pc,
	output logic                       o_push_fault
);
	import fetch_pkg::*;

	fetch_state_e    state;
	logic [XLEN-1:0] pc;
	logic            in_flight;
	logic            irq_prev;
	logic            irq_latched;
	logic            irq_edge;
	logic            irq_take;

	assign irq_edge = i_irq_pending & ~irq_prev;

	// Never interrupt a transfer, the word would be lost
	assign irq_take = (irq_latched | irq_edge) & ~in_flight
		& (state == ST_FETCH || state == ST_WAIT_IRQ);

	assign o_start = (state == ST_FETCH) & ~in_flight & i_room & ~irq_take;
	assign o_address = pc;

	// PC still points at the word in flight until done
	assign o_push = i_done;
	assign o_push_pc = pc;
	assign o_push_fault = i_error;

	// Edge detect sampler
	always_ff @(posedge i_clock) begin
		irq_prev <= i_irq_pending;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_FETCH;
			pc <= RESET_VECTOR;
			in_flight <= 1'b0;
			irq_latched <= 1'b0;
			o_irq_dispatched <= 1'b0;
		end
		else begin
			o_irq_dispatched <= 1'b0;

			if (irq_take) begin
				irq_latched <= 1'b0;
			end
			else if (irq_edge) begin
				irq_latched <= 1'b1;
			end

			if (o_start) begin
				in_flight <= 1'b1;
			end
			else if (i_done) begin
				in_flight <= 1'b0;
			end

			if (irq_take) begin
				o_irq_dispatched <= 1'b1;
				o_irq_epc <= pc;
				pc <= i_irq_pc;
				state <= ST_FETCH;
			end
			else begin
				case (state)
					ST_FETCH: begin
						if (i_done) begin
							pc <= pc + XLEN'(4);
							if (i_error || i_flow == FLOW_WAIT_JUMP) begin
								state <= ST_WAIT_JUMP;
							end
							else if (i_flow == FLOW_WAIT_IRQ) begin
								state <= ST_WAIT_IRQ;
							end
						end
					end
					ST_WAIT_JUMP: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= ST_FETCH;
						end
					end
					ST_WAIT_IRQ: begin
						// Left only through irq_take
						state <= ST_WAIT_IRQ;
					end
					default: begin
						state <= ST_FETCH;
					end
				endcase
			end
		end
	end

	a_push_after_start: assert property (@(posedge i_clock) disable iff (i_reset)
		o_push |-> in_flight)
		else $error("Push without a transfer started earlier");

	a_state_legal: assert property (@(posedge i_clock) disable iff (i_reset)
		state inside {ST_FETCH, ST_WAIT_JUMP, ST_WAIT_IRQ})
		else $error("Fetch sequencer in an illegal state");

endmodule

// ==== hw/fetch_result_buffer.sv ====
// Two-entry FIFO with registered outputs. A push is visible at o_valid one cycle later.
module fetch_result_buffer (
	input  logic                                  i_clock,
	input  logic                                  i_reset,
	input  logic                                  i_push,
	input  logic [fetch_pkg::XLEN-1:0]            i_pc,
	input  logic [fetch_pkg::XLEN-1:0]            i_instruction,
	input  logic [fetch_pkg::REG_INDEX_WIDTH-1:0] i_rs1,
	input  logic [fetch_pkg::REG_INDEX_WIDTH-1:0] i_rs2,
	input  logic [fetch_pkg::REG_INDEX_WIDTH-1:0] i_rs3,
	input  logic [fetch_pkg::REG_INDEX_WIDTH-1:0] i_rd,
	input  logic                                  i_fault,
	output logic                                  o_room,
	output logic                                  o_valid,
	input  logic                                  i_ready,
	output logic [fetch_pkg::XLEN-1:0]            o_pc,
	output logic [fetch_pkg::XLEN-1:0]            o_instruction,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rs1,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rs2,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rs3,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rd,
	output logic                                  o_fault
);
	import fetch_pkg::*;

	localparam int ENTRY_WIDTH = 2 * XLEN + 4 * REG_INDEX_WIDTH + 1;

	logic [ENTRY_WIDTH-1:0] entries [2];
	logic                   wr_ptr;
	logic                   rd_ptr;
	logic [1:0]             count;
	logic                   pop;

	assign o_valid = (count != 2'd0);
	assign pop = o_valid & i_ready;

	// Room counts the entry being pushed, pops are not credited
	assign o_room = i_push ? (count == 2'd0) : (count != 2'd2);

	assign {o_pc, o_instruction, o_rs1, o_rs2, o_rs3, o_rd, o_fault} = entries[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (i_push) begin
			entries[wr_ptr] <= {i_pc, i_instruction, i_rs1, i_rs2, i_rs3, i_rd, i_fault};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end
		else begin
			if (i_push) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			count <= count + 2'(i_push) - 2'(pop);
		end
	end

	a_no_push_full: assert property (@(posedge i_clock) disable iff (i_reset)
		i_push |-> (count != 2'd2))
		else $error("Result buffer pushed while full");

	a_hold_stalled: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_valid && !i_ready) |=> (o_valid && $stable({o_pc, o_instruction, o_rs1,
			o_rs2, o_rs3, o_rd, o_fault})))
		else $error("Result output changed while stalled");

endmodule

// ==== hw/fetch_top.sv ====
// Fetch front end top. Needs an APB completer for instruction reads and starts at RESET_VECTOR.
module fetch_top #(
	parameter logic [fetch_pkg::XLEN-1:0] RESET_VECTOR = '0
) (
	input  logic                                  i_clock,
	input  logic                                  i_reset,

	// APB requester
	output logic                                  o_psel,
	output logic                                  o_penable,
	output logic [fetch_pkg::XLEN-1:0]            o_paddr,
	input  logic [fetch_pkg::XLEN-1:0]            i_prdata,
	input  logic                                  i_pready,
	input  logic                                  i_pslverr,

	// To decode
	output logic                                  o_valid,
	input  logic                                  i_ready,
	output logic [fetch_pkg::XLEN-1:0]            o_pc,
	output logic [fetch_pkg::XLEN-1:0]            o_instruction,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rs1,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rs2,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rs3,
	output logic [fetch_pkg::REG_INDEX_WIDTH-1:0] o_rd,
	output logic                                  o_fault,

	// Control
	input  logic                                  i_jump,
	input  logic [fetch_pkg::XLEN-1:0]            i_jump_pc,

	// Interrupt
	input  logic                                  i_irq_pending,
	input  logic [fetch_pkg::XLEN-1:0]            i_irq_pc,
	output logic                                  o_irq_dispatched,
	output logic [fetch_pkg::XLEN-1:0]            o_irq_epc
);
	import fetch_pkg::*;

	logic                       start;
	logic [XLEN-1:0]            address;
	logic                       done;
	logic [XLEN-1:0]            rdata;
	logic                       error;
	flow_class_e                flow;
	logic [REG_INDEX_WIDTH-1:0] rs1;
	logic [REG_INDEX_WIDTH-1:0] rs2;
	logic [REG_INDEX_WIDTH-1:0] rs3;
	logic [REG_INDEX_WIDTH-1:0] rd;
	logic                       room;
	logic                       push;
	logic [XLEN-1:0]            push_pc;
	logic                       push_fault;

	fetch_predecode u_predecode (
		.i_instruction (rdata),
		.o_opcode      (),
		.o_flow        (flow),
		.o_rs1         (rs1),
		.o_rs2         (rs2),
		.o_rs3         (rs3),
		.o_rd          (rd)
	);

	fetch_apb_requester u_apb_requester (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_start   (start),
		.i_address (address),
		.o_done    (done),
		.o_rdata   (rdata),
		.o_error   (error),
		.o_psel    (o_psel),
		.o_penable (o_penable),
		.o_paddr   (o_paddr),
		.i_prdata  (i_prdata),
		.i_pready  (i_pready),
		.i_pslverr (i_pslverr)
	);

	fetch_sequencer #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_sequencer (
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_jump           (i_jump),
		.i_jump_pc        (i_jump_pc),
		.i_irq_pending    (i_irq_pending),
		.i_irq_pc         (i_irq_pc),
		.o_irq_dispatched (o_irq_dispatched),
		.o_irq_epc        (o_irq_epc),
		.o_start          (start),
		.o_address        (address),
		.i_done           (done),
		.i_error          (error),
		.i_flow           (flow),
		.i_room           (room),
		.o_push           (push),
		.o_push_pc        (push_pc),
		.o_push_fault     (push_fault)
	);

	fetch_result_buffer u_result_buffer (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_push        (push),
		.i_pc          (push_pc),
		.i_instruction (rdata),
		.i_rs1         (rs1),
		.i_rs2         (rs2),
		.i_rs3         (rs3),
		.i_rd          (rd),
		.i_fault       (push_fault),
		.o_room        (room),
		.o_valid       (o_valid),
		.i_ready       (i_ready),
		.o_pc          (o_pc),
		.o_instruction (o_instruction),
		.o_rs1         (o_rs1),
		.o_rs2         (o_rs2),
		.o_rs3         (o_rs3),
		.o_rd          (o_rd),
		.o_fault       (o_fault)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
// Free-running clock of period 10 and a reset that holds for the first 5 rising edges.
module tb_clock_gen (
	output logic o_clock,
	output logic o_reset
);
	initial begin
		o_clock = 1'b0;
		forever #5 o_clock = ~o_clock;
	end

	initial begin
		o_reset = 1'b1;
		repeat (5) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

// ==== tb/tb_apb_memory.sv ====
// APB read completer over 64 words from BASE; addresses outside the window alias into it.
module tb_apb_memory #(
	parameter logic [31:0] BASE     = 32'h0000_0100,
	parameter logic [31:0] ERR_ADDR = 32'h0000_01c8
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_psel,
	input  logic        i_penable,
	input  logic [31:0] i_paddr,
	output logic [31:0] o_prdata,
	output logic        o_pready,
	output logic        o_pslverr
);
	logic [31:0] mem [64];
	logic [31:0] fill_addr;
	logic [1:0]  wait_cnt;
	integer      seed = 90;

	// Fill with addi x1, x2, imm where imm is the low 12 address bits
	initial begin
		for (int i = 0; i < 64; i++) begin
			fill_addr = BASE + 32'(i * 4);
			mem[i] = {fill_addr[11:0], 5'd2, 3'b000, 5'd1, 7'b0010011};
		end
		mem[0] = 32'h0050_0093;
		mem[1] = 32'h0040_a103;
		mem[2] = 32'h0020_a423;
		mem[3] = 32'h0020_81b3;
		mem[4] = 32'h1234_5237;
		// fmadd with rs3=5 rs2=6 rs1=7 rd=8
		mem[5] = {5'd5, 2'b00, 5'd6, 5'd7, 3'b000, 5'd8, 7'b1000011};
		mem[6] = 32'h0080_00ef;
		mem[33] = 32'h0000_0073;
	end

	assign o_prdata = mem[i_paddr[7:2]];
	// PENABLE is high only in access cycles, so PREADY follows it alone
	assign o_pready = i_penable & (wait_cnt == 2'd0);
	assign o_pslverr = o_pready & (i_paddr == ERR_ADDR);

	// Zero to three wait states, drawn in the setup cycle
	always @(posedge i_clock) begin
		if (i_reset) begin
			wait_cnt <= 2'd0;
		end
		else if (i_psel && !i_penable) begin
			wait_cnt <= 2'($random(seed));
		end
		else if (i_psel && i_penable && wait_cnt != 2'd0) begin
			wait_cnt <= wait_cnt - 2'd1;
		end
	end

endmodule

// ==== tb/tb_fetch_top.sv ====
// Runs the fixed program at 0x100 through the fetch front end; the run is capped at 4000 cycles.
module tb_fetch_top;
	localparam int MAX_CYCLES = 4000;

	logic        clock;
	logic        reset;
	logic        psel;
	logic        penable;
	logic [31:0] paddr;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        o_valid;
	logic        i_ready = 1'b0;
	logic [31:0] o_pc;
	logic [31:0] o_instruction;
	logic [4:0]  o_rs1;
	logic [4:0]  o_rs2;
	logic [4:0]  o_rs3;
	logic [4:0]  o_rd;
	logic        o_fault;
	logic        i_jump;
	logic [31:0] i_jump_pc;
	logic        i_irq_pending;
	logic [31:0] i_irq_pc;
	logic        o_irq_dispatched;
	logic [31:0] o_irq_epc;

	logic        hold_fetch;
	logic        stall;
	logic [31:0] exp_pc;
	logic [31:0] exp_word;
	logic [19:0] exp_fields;
	integer      seed = 90;
	integer      cycles = 0;
	integer      setups = 0;
	integer      dispatches = 0;
	integer      check_errors = 0;
	integer      other_errors = 0;
	integer      tests = 0;
	integer      failed = 0;
	integer      base_errors;
	integer      base_setups;

	tb_clock_gen u_clock_gen (.o_clock(clock), .o_reset(reset));

	tb_apb_memory u_mem (
		.i_clock(clock), .i_reset(reset), .i_psel(psel), .i_penable(penable),
		.i_paddr(paddr), .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
	);

	fetch_top #(.RESET_VECTOR(32'h0000_0100)) u_dut (
		.i_clock(clock), .i_reset(reset),
		.o_psel(psel), .o_penable(penable), .o_paddr(paddr),
		.i_prdata(prdata), .i_pready(pready), .i_pslverr(pslverr),
		.o_valid(o_valid), .i_ready(i_ready), .o_pc(o_pc), .o_instruction(o_instruction),
		.o_rs1(o_rs1), .o_rs2(o_rs2), .o_rs3(o_rs3), .o_rd(o_rd), .o_fault(o_fault),
		.i_jump(i_jump), .i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending), .i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched), .o_irq_epc(o_irq_epc)
	);

	// Register fields by format as {rs1, rs2, rs3, rd}, x0 where the format has none
	function automatic logic [19:0] format_fields(input logic [31:0] w);
		logic [4:0] a;
		logic [4:0] b;
		logic [4:0] c;
		logic [4:0] d;
		a = w[19:15];
		b = w[24:20];
		c = w[31:27];
		d = w[11:7];
		case (w[6:0])
			7'b0110011: return {a, b, 5'd0, d};
			7'b0000011, 7'b0010011, 7'b1100111, 7'b1110011: return {a, 5'd0, 5'd0, d};
			7'b0100011, 7'b1100011: return {a, b, 5'd0, 5'd0};
			7'b0110111, 7'b0010111, 7'b1101111: return {15'd0, d};
			7'b1000011, 7'b1000111, 7'b1001011, 7'b1001111: return {a, b, c, d};
			default: return 20'd0;
		endcase
	endfunction

	assign exp_word = u_mem.mem[exp_pc[7:2]];
	assign exp_fields = format_fields(exp_word);

	// Reference PC follows transfers, jumps and dispatches
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (reset) begin
			exp_pc <= 32'h0000_0100;
		end
		else begin
			if (o_valid && i_ready) exp_pc <= exp_pc + 32'd4;
			if (i_jump) exp_pc <= i_jump_pc;
			if (o_irq_dispatched) exp_pc <= i_irq_pc;
			if (psel && !penable) setups <= setups + 1;
			if (o_irq_dispatched) dispatches <= dispatches + 1;
		end
	end

	always @(posedge clock) begin
		i_ready <= stall ? 1'b0 : (({$random(seed)} % 3) != 0);
	end

	a_pc: assert property (@(posedge clock) disable iff (reset)
		(o_valid && i_ready) |-> o_pc == exp_pc)
		else begin
			check_errors++;
			$display("mismatch o_pc: got %h expected %h", o_pc, exp_pc);
		end

	a_word: assert property (@(posedge clock) disable iff (reset)
		(o_valid && i_ready) |-> o_instruction == exp_word)
		else begin
			check_errors++;
			$display("mismatch o_instruction: got %h expected %h", o_instruction, exp_word);
		end

	a_fields: assert property (@(posedge clock) disable iff (reset)
		(o_valid && i_ready) |-> {o_rs1, o_rs2, o_rs3, o_rd} == exp_fields)
		else begin
			check_errors++;
			$display("mismatch o_rs1/o_rs2/o_rs3/o_rd: got %h expected %h",
				{o_rs1, o_rs2, o_rs3, o_rd}, exp_fields);
		end

	a_fault: assert property (@(posedge clock) disable iff (reset)
		(o_valid && i_ready) |-> o_fault == (exp_pc == 32'h0000_01c8))
		else begin
			check_errors++;
			$display("mismatch o_fault: got %h expected %h", o_fault,
				(exp_pc == 32'h0000_01c8));
		end

	a_no_fetch: assert property (@(posedge clock) disable iff (reset)
		hold_fetch |-> !(psel && !penable))
		else begin
			check_errors++;
			$display("APB setup seen while fetch should be stopped");
		end

	a_epc: assert property (@(posedge clock) disable iff (reset)
		o_irq_dispatched |-> o_irq_epc == 32'h0000_0188)
		else begin
			check_errors++;
			$display("mismatch o_irq_epc: got %h expected %h", o_irq_epc, 32'h0000_0188);
		end

	a_stable: assert property (@(posedge clock) disable iff (reset)
		(o_valid && !i_ready) |=> o_valid && $stable({o_pc, o_instruction, o_rs1, o_rs2,
			o_rs3, o_rd, o_fault}))
		else begin
			check_errors++;
			$display("Result output changed while the consumer stalled");
		end

	always @(posedge clock) begin
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped by timeout after %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic wait_transfer(input logic [31:0] pc);
		do @(posedge clock); while (!(o_valid && i_ready && o_pc == pc));
	endtask

	task automatic start_test();
		base_errors = check_errors + other_errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (check_errors + other_errors != base_errors) begin
			failed++;
			$display("Test %s: failed", name);
		end
		else begin
			$display("Test %s: ok", name);
		end
	endtask

	initial begin
		i_jump = 1'b0;
		i_jump_pc = 32'd0;
		i_irq_pending = 1'b0;
		i_irq_pc = 32'd0;
		hold_fetch = 1'b0;
		stall = 1'b0;
		wait (!reset);

		start_test();
		wait_transfer(32'h0000_0118);
		hold_fetch <= 1'b1;
		end_test("sequential words and register fields");

		start_test();
		repeat (12) @(posedge clock);
		hold_fetch <= 1'b0;
		i_jump <= 1'b1;
		i_jump_pc <= 32'h0000_0180;
		@(posedge clock);
		i_jump <= 1'b0;
		wait_transfer(32'h0000_0180);
		end_test("jump after JAL");

		start_test();
		wait_transfer(32'h0000_0184);
		hold_fetch <= 1'b1;
		repeat (12) @(posedge clock);
		hold_fetch <= 1'b0;
		i_irq_pending <= 1'b1;
		i_irq_pc <= 32'h0000_01c0;
		wait_transfer(32'h0000_01c0);
		if (dispatches != 1) begin
			other_errors++;
			$display("Interrupt dispatched %0d times instead of once", dispatches);
		end
		end_test("ECALL waits for interrupt");

		start_test();
		wait_transfer(32'h0000_01c8);
		hold_fetch <= 1'b1;
		repeat (12) @(posedge clock);
		i_irq_pending <= 1'b0;
		end_test("APB error gives a faulted word");

		start_test();
		hold_fetch <= 1'b0;
		stall <= 1'b1;
		i_jump <= 1'b1;
		i_jump_pc <= 32'h0000_0140;
		@(posedge clock);
		i_jump <= 1'b0;
		base_setups = setups;
		repeat (30) @(posedge clock);
		if (setups - base_setups > 2) begin
			other_errors++;
			$display("Fetched %0d words while the consumer stalled", setups - base_setups);
		end
		stall <= 1'b0;
		wait_transfer(32'h0000_015c);
		end_test("back-pressure");

		$display("Tests run %0d, failed %0d, errors %0d", tests, failed,
			check_errors + other_errors);
		if (failed == 0 && check_errors + other_errors == 0) begin
			$display("Simulation finished: PASS");
		end
		else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== build.f ====
hw/fetch_pkg.sv
hw/fetch_predecode.sv
hw/fetch_apb_requester.sv
hw/fetch_sequencer.sv
hw/fetch_result_buffer.sv
hw/fetch_top.sv
tb/tb_clock_gen.sv
tb/tb_apb_memory.sv
tb/tb_fetch_top.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_fetch_top
FILELIST  = build.f
PASS_TEXT = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
